// File: logic/execute_writeback.sv
module execute_writeback (
   input  logic                          clk,
   input  logic                          rst_n,
   input  pipe_pkg::ex_op_t              issue_op,
   output pipe_pkg::wb_op_t              alu_pending,
   output pipe_pkg::wb_op_t              wb_pending,
   output logic                          wr_en,
   output logic [pipe_pkg::reg_id_w-1:0] wr_idx,
   output logic [pipe_pkg::data_w-1:0]   wr_data,
   output logic                          retire
);

   logic [pipe_pkg::data_w-1:0] alu_result;
   pipe_pkg::wb_op_t            wb_q;

   // Add and sub wrap and keep no flags
   always_comb begin
      case (issue_op.aluk)
         pipe_pkg::aluk_add: alu_result = issue_op.a + issue_op.b;
         pipe_pkg::aluk_sub: alu_result = issue_op.a - issue_op.b;
         pipe_pkg::aluk_and: alu_result = issue_op.a & issue_op.b;
         pipe_pkg::aluk_or:  alu_result = issue_op.a | issue_op.b;
         pipe_pkg::aluk_xor: alu_result = issue_op.a ^ issue_op.b;
         default:            alu_result = issue_op.b;
      endcase
   end

   assign alu_pending = '{valid:  issue_op.valid,
                          dest:   issue_op.dest,
                          writes: issue_op.writes,
                          result: alu_result};

   // Writeback latch
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_q <= '0;
      end else begin
         wb_q <= alu_pending;
      end
   end

   assign wb_pending = wb_q;
   assign wr_en      = wb_q.valid && wb_q.writes;
   assign wr_idx     = wb_q.dest;
   assign wr_data    = wb_q.result;
   assign retire     = wb_q.valid;

   // Writes retire and an add or sub result undoes with operand b
   a_write_retires: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> retire &&
                ($past(issue_op.aluk) != pipe_pkg::aluk_add ||
                 wr_data - $past(issue_op.b) == $past(issue_op.a)) &&
                ($past(issue_op.aluk) != pipe_pkg::aluk_sub ||
                 wr_data + $past(issue_op.b) == $past(issue_op.a)));

endmodule

// File: logic/gpr_file.sv
module gpr_file (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [pipe_pkg::reg_id_w-1:0] rd_idx_a,
   input  logic [pipe_pkg::reg_id_w-1:0] rd_idx_b,
   input  logic [pipe_pkg::reg_id_w-1:0] rd_idx_c,
   output logic [pipe_pkg::data_w-1:0]   rd_data_a,
   output logic [pipe_pkg::data_w-1:0]   rd_data_b,
   output logic [pipe_pkg::data_w-1:0]   rd_data_c,
   input  logic                          wr_en,
   input  logic [pipe_pkg::reg_id_w-1:0] wr_idx,
   input  logic [pipe_pkg::data_w-1:0]   wr_data
);

   logic [pipe_pkg::data_w-1:0] regs [pipe_pkg::num_gprs];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < pipe_pkg::num_gprs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // Reads see the old value during the write cycle
   assign rd_data_a = regs[rd_idx_a];
   assign rd_data_b = regs[rd_idx_b];
   assign rd_data_c = regs[rd_idx_c];

endmodule

// File: logic/instr_write_port.sv
module instr_write_port (
   input  logic                        clk,
   input  logic                        rst_n,
   input  pipe_pkg::axil_wr_req_t      wr_req,
   output pipe_pkg::axil_wr_rsp_t      wr_rsp,
   output logic [pipe_pkg::data_w-1:0] head_word,
   output logic                        head_valid,
   input  logic                        head_pop
);

   logic [pipe_pkg::data_w-1:0]                    queue [pipe_pkg::queue_depth];
   logic [$clog2(pipe_pkg::queue_depth)-1:0]       wr_ptr;
   logic [$clog2(pipe_pkg::queue_depth)-1:0]       rd_ptr;
   logic [$clog2(pipe_pkg::queue_depth + 1)-1:0]   count;
   logic                                           full;
   logic                                           ready;
   logic                                           accept;
   logic                                           push;
   logic                                           bvalid_q;
   logic [1:0]                                     bresp_q;

   assign full   = (count == pipe_pkg::queue_depth);
   // AW and W are only taken together
   assign ready  = !bvalid_q && !full;
   assign accept = wr_req.awvalid && wr_req.wvalid && ready;
   assign push   = accept && (wr_req.awaddr == pipe_pkg::instr_addr);

   // Write response held until the manager takes it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bvalid_q <= 1'b0;
         bresp_q  <= pipe_pkg::resp_okay;
      end else if (accept) begin
         bvalid_q <= 1'b1;
         bresp_q  <= push ? pipe_pkg::resp_okay : pipe_pkg::resp_slverr;
      end else if (wr_req.bready) begin
         bvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         queue[wr_ptr] <= wr_req.wdata;
      end
   end

   // Circular pointers wrap on the power of two depth
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (head_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, head_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign head_word  = queue[rd_ptr];
   assign head_valid = (count != '0);

   assign wr_rsp.awready = ready;
   assign wr_rsp.wready  = ready;
   assign wr_rsp.bvalid  = bvalid_q;
   assign wr_rsp.bresp   = bresp_q;

   // Count never passes the depth and agrees with the pointers
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      count <= pipe_pkg::queue_depth &&
      wr_ptr - rd_ptr == count[$clog2(pipe_pkg::queue_depth)-1:0]);

   // Issue stage must only pop a word that is really queued
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      head_pop |-> count != '0);

endmodule

// File: logic/issue_stage.sv
module issue_stage (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [pipe_pkg::data_w-1:0]   head_word,
   input  logic                          head_valid,
   output logic                          head_pop,
   output logic [pipe_pkg::reg_id_w-1:0] rd_idx_a,
   output logic [pipe_pkg::reg_id_w-1:0] rd_idx_b,
   input  logic [pipe_pkg::data_w-1:0]   rd_data_a,
   input  logic [pipe_pkg::data_w-1:0]   rd_data_b,
   input  pipe_pkg::wb_op_t              alu_pending,
   input  pipe_pkg::wb_op_t              wb_pending,
   output pipe_pkg::ex_op_t              issue_op
);

   pipe_pkg::instr_word_u instr;
   pipe_pkg::aluk_t       aluk;
   pipe_pkg::ex_op_t      next_op;
   logic                  known_op;
   logic                  reg_form;
   logic                  dep_a;
   logic                  dep_b;
   logic                  dep_hit;

   // Pending op that will still write idx
   function automatic logic owes(input pipe_pkg::wb_op_t op,
                                 input logic [pipe_pkg::reg_id_w-1:0] idx);
      return op.valid && op.writes && (op.dest == idx);
   endfunction

   assign instr    = head_word;
   assign reg_form = (instr.rr.modrm.mod == pipe_pkg::mod_reg);
   assign rd_idx_a = instr.rr.modrm.rm;
   assign rd_idx_b = instr.rr.modrm.reg_f;

   always_comb begin
      known_op = 1'b1;
      case (instr.rr.opcode)
         pipe_pkg::op_add: aluk = pipe_pkg::aluk_add;
         pipe_pkg::op_or:  aluk = pipe_pkg::aluk_or;
         pipe_pkg::op_and: aluk = pipe_pkg::aluk_and;
         pipe_pkg::op_sub: aluk = pipe_pkg::aluk_sub;
         pipe_pkg::op_xor: aluk = pipe_pkg::aluk_xor;
         pipe_pkg::op_mov: aluk = pipe_pkg::aluk_pass_b;
         default: begin
            // Unknown opcode still retires but writes nothing
            aluk     = pipe_pkg::aluk_pass_b;
            known_op = 1'b0;
         end
      endcase
   end

   // Dependency check against ALU latch and writeback latch
   assign dep_a   = owes(alu_pending, instr.rr.modrm.rm) ||
                    owes(wb_pending, instr.rr.modrm.rm);
   assign dep_b   = reg_form && (owes(alu_pending, instr.rr.modrm.reg_f) ||
                                 owes(wb_pending, instr.rr.modrm.reg_f));
   assign dep_hit = head_valid && (dep_a || dep_b);
   assign head_pop = head_valid && !dep_hit;

   always_comb begin
      next_op.valid  = head_pop;
      next_op.aluk   = aluk;
      next_op.dest   = instr.rr.modrm.rm;
      next_op.writes = known_op;
      next_op.a      = rd_data_a;
      next_op.b      = reg_form ? rd_data_b : pipe_pkg::data_w'(instr.ri.imm16);
   end

   // This register is the ALU latch
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issue_op <= '0;
      end else begin
         issue_op <= next_op;
      end
   end

   // Never pop a source that one of the last two issued ops still writes
   a_no_pop_on_dep: assert property (@(posedge clk) disable iff (!rst_n)
      head_pop |-> !(issue_op.valid && issue_op.writes &&
                     (issue_op.dest == rd_idx_a ||
                      (reg_form && issue_op.dest == rd_idx_b))) &&
                   !($past(issue_op.valid && issue_op.writes) &&
                     ($past(issue_op.dest) == rd_idx_a ||
                      (reg_form && $past(issue_op.dest) == rd_idx_b))));

endmodule

// File: logic/mini_x86_pipe.sv
module mini_x86_pipe (
   input  logic                   clk,
   input  logic                   rst_n,
   input  pipe_pkg::axil_wr_req_t wr_req,
   output pipe_pkg::axil_wr_rsp_t wr_rsp,
   input  pipe_pkg::axil_rd_req_t rd_req,
   output pipe_pkg::axil_rd_rsp_t rd_rsp
);

   logic [pipe_pkg::data_w-1:0]   head_word;
   logic                          head_valid;
   logic                          head_pop;
   logic [pipe_pkg::reg_id_w-1:0] rd_idx_a;
   logic [pipe_pkg::reg_id_w-1:0] rd_idx_b;
   logic [pipe_pkg::reg_id_w-1:0] rd_idx_c;
   logic [pipe_pkg::data_w-1:0]   rd_data_a;
   logic [pipe_pkg::data_w-1:0]   rd_data_b;
   logic [pipe_pkg::data_w-1:0]   rd_data_c;
   pipe_pkg::ex_op_t              issue_op;
   pipe_pkg::wb_op_t              alu_pending;
   pipe_pkg::wb_op_t              wb_pending;
   logic                          wr_en;
   logic [pipe_pkg::reg_id_w-1:0] wr_idx;
   logic [pipe_pkg::data_w-1:0]   wr_data;
   logic                          retire;

   // Instruction words in over AXI4-Lite write
   instr_write_port u_instr_write_port (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_req     (wr_req),
      .wr_rsp     (wr_rsp),
      .head_word  (head_word),
      .head_valid (head_valid),
      .head_pop   (head_pop)
   );

   issue_stage u_issue_stage (
      .clk         (clk),
      .rst_n       (rst_n),
      .head_word   (head_word),
      .head_valid  (head_valid),
      .head_pop    (head_pop),
      .rd_idx_a    (rd_idx_a),
      .rd_idx_b    (rd_idx_b),
      .rd_data_a   (rd_data_a),
      .rd_data_b   (rd_data_b),
      .alu_pending (alu_pending),
      .wb_pending  (wb_pending),
      .issue_op    (issue_op)
   );

   gpr_file u_gpr_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_idx_c  (rd_idx_c),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .rd_data_c (rd_data_c),
      .wr_en     (wr_en),
      .wr_idx    (wr_idx),
      .wr_data   (wr_data)
   );

   execute_writeback u_execute_writeback (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_op    (issue_op),
      .alu_pending (alu_pending),
      .wb_pending  (wb_pending),
      .wr_en       (wr_en),
      .wr_idx      (wr_idx),
      .wr_data     (wr_data),
      .retire      (retire)
   );

   // Registers and retired count out over AXI4-Lite read
   status_read_port u_status_read_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_req    (rd_req),
      .rd_rsp    (rd_rsp),
      .rd_idx_c  (rd_idx_c),
      .rd_data_c (rd_data_c),
      .retire    (retire)
   );

endmodule

// File: logic/pipe_pkg.sv
package pipe_pkg;

   localparam int data_w      = 32;
   localparam int addr_w      = 8;
   localparam int reg_id_w    = 3;
   localparam int num_gprs    = 8;
   localparam int queue_depth = 4;
   localparam int count_w     = 16;

   localparam logic [addr_w-1:0] instr_addr   = 8'h00;
   localparam logic [addr_w-1:0] retired_addr = 8'h20;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // Opcodes, all in the r/m32 destination form
   localparam logic [7:0] op_add = 8'h01;
   localparam logic [7:0] op_or  = 8'h09;
   localparam logic [7:0] op_and = 8'h21;
   localparam logic [7:0] op_sub = 8'h29;
   localparam logic [7:0] op_xor = 8'h31;
   localparam logic [7:0] op_mov = 8'h89;

   localparam logic [1:0] mod_reg = 2'b11;

   typedef enum logic [2:0] {
      aluk_add    = 3'd0,
      aluk_sub    = 3'd1,
      aluk_and    = 3'd2,
      aluk_or     = 3'd3,
      aluk_xor    = 3'd4,
      aluk_pass_b = 3'd5
   } aluk_t;

   typedef struct packed {
      logic [1:0] mod;
      logic [2:0] reg_f;
      logic [2:0] rm;
   } modrm_t;

   typedef struct packed {
      logic [7:0]  opcode;
      modrm_t      modrm;
      logic [15:0] reserved;
   } instr_rr_t;

   typedef struct packed {
      logic [7:0]  opcode;
      modrm_t      modrm;
      logic [15:0] imm16;
   } instr_ri_t;

   // Register form when modrm.mod is mod_reg, immediate form otherwise
   typedef union packed {
      instr_rr_t rr;
      instr_ri_t ri;
   } instr_word_u;

   typedef struct packed {
      logic                valid;
      aluk_t               aluk;
      logic [reg_id_w-1:0] dest;
      logic                writes;
      logic [data_w-1:0]   a;
      logic [data_w-1:0]   b;
   } ex_op_t;

   typedef struct packed {
      logic                valid;
      logic [reg_id_w-1:0] dest;
      logic                writes;
      logic [data_w-1:0]   result;
   } wb_op_t;

   typedef struct packed {
      logic              awvalid;
      logic [addr_w-1:0] awaddr;
      logic              wvalid;
      logic [data_w-1:0] wdata;
      logic              bready;
   } axil_wr_req_t;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      logic [1:0] bresp;
   } axil_wr_rsp_t;

   typedef struct packed {
      logic              arvalid;
      logic [addr_w-1:0] araddr;
      logic              rready;
   } axil_rd_req_t;

   typedef struct packed {
      logic              arready;
      logic              rvalid;
      logic [data_w-1:0] rdata;
      logic [1:0]        rresp;
   } axil_rd_rsp_t;

endpackage

// File: logic/status_read_port.sv
module status_read_port (
   input  logic                          clk,
   input  logic                          rst_n,
   input  pipe_pkg::axil_rd_req_t        rd_req,
   output pipe_pkg::axil_rd_rsp_t        rd_rsp,
   output logic [pipe_pkg::reg_id_w-1:0] rd_idx_c,
   input  logic [pipe_pkg::data_w-1:0]   rd_data_c,
   input  logic                          retire
);

   logic                         rvalid_q;
   logic [pipe_pkg::data_w-1:0]  rdata_q;
   logic [1:0]                   rresp_q;
   logic [pipe_pkg::count_w-1:0] retired;
   logic                         rd_accept;
   logic                         gpr_hit;

   assign rd_accept = rd_req.arvalid && !rvalid_q;
   // Word aligned 0x00..0x1C map onto the register file
   assign gpr_hit   = (rd_req.araddr < pipe_pkg::addr_w'(4 * pipe_pkg::num_gprs)) &&
                      (rd_req.araddr[1:0] == 2'b00);
   assign rd_idx_c  = rd_req.araddr[2 +: pipe_pkg::reg_id_w];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         retired <= '0;
      end else if (retire) begin
         retired <= retired + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rvalid_q <= 1'b0;
      end else if (rd_accept) begin
         rvalid_q <= 1'b1;
      end else if (rd_req.rready) begin
         rvalid_q <= 1'b0;
      end
   end

   // Data captured at acceptance and held for the beat
   always_ff @(posedge clk) begin
      if (rd_accept) begin
         if (gpr_hit) begin
            rdata_q <= rd_data_c;
            rresp_q <= pipe_pkg::resp_okay;
         end else if (rd_req.araddr == pipe_pkg::retired_addr) begin
            rdata_q <= pipe_pkg::data_w'(retired);
            rresp_q <= pipe_pkg::resp_okay;
         end else begin
            rdata_q <= '0;
            rresp_q <= pipe_pkg::resp_slverr;
         end
      end
   end

   assign rd_rsp.arready = !rvalid_q;
   assign rd_rsp.rvalid  = rvalid_q;
   assign rd_rsp.rdata   = rdata_q;
   assign rd_rsp.rresp   = rresp_q;

   a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid_q && !rd_req.rready |=>
         rd_rsp.rvalid && $stable(rd_rsp.rdata) && $stable(rd_rsp.rresp));

endmodule

// File: mini_x86_pipe.f
logic/pipe_pkg.sv
logic/instr_write_port.sv
logic/issue_stage.sv
logic/gpr_file.sv
logic/execute_writeback.sv
logic/status_read_port.sv
logic/mini_x86_pipe.sv
tests/tb_mini_x86_pipe.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, then run it.
# The exit status is nonzero if the build fails or the simulation stops on $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_mini_x86_pipe \
   -f mini_x86_pipe.f \
   --Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit "$status"
fi

exit 0

// File: tests/tb_mini_x86_pipe.sv
module tb_mini_x86_pipe;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_load   = 9;
   localparam int chain_len  = 16;
   localparam int num_random = 200;
   localparam int num_sent   = num_load + 12 + chain_len + 2 + 3 + num_random;
   localparam int watchdog_cycles = 200 * num_sent + 1000;

   logic                   clk = 1'b0;
   logic                   rst_n;
   pipe_pkg::axil_wr_req_t wr_req;
   pipe_pkg::axil_wr_rsp_t wr_rsp;
   pipe_pkg::axil_rd_req_t rd_req;
   pipe_pkg::axil_rd_rsp_t rd_rsp;

   // Reference state updated as each instruction is sent
   logic [31:0] model_regs [pipe_pkg::num_gprs];
   logic [31:0] model_retired;

   integer      seed = 32'h39a;
   string       check_name;
   event        check_now;
   event        check_done;
   logic [7:0]  probe_addrs [3] = '{8'h24, 8'h06, 8'hf0};

   mini_x86_pipe i_mini_x86_pipe (
      .clk    (clk),
      .rst_n  (rst_n),
      .wr_req (wr_req),
      .wr_rsp (wr_rsp),
      .rd_req (rd_req),
      .rd_rsp (rd_rsp)
   );

   always #50 clk = ~clk;

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      $display("sim failed");
      $fatal(1, "stopped at first error");
   endtask

   function automatic logic [7:0] op_by_index(input int idx);
      case (idx)
         0:       return pipe_pkg::op_add;
         1:       return pipe_pkg::op_or;
         2:       return pipe_pkg::op_and;
         3:       return pipe_pkg::op_sub;
         4:       return pipe_pkg::op_xor;
         5:       return pipe_pkg::op_mov;
         default: return 8'h0f;
      endcase
   endfunction

   function automatic logic [31:0] encode(input logic [7:0] opcode, input logic [1:0] mod,
                                          input logic [2:0] reg_f, input logic [2:0] rm,
                                          input logic [15:0] low);
      pipe_pkg::instr_word_u w;
      w.ri.opcode       = opcode;
      w.ri.modrm.mod    = mod;
      w.ri.modrm.reg_f  = reg_f;
      w.ri.modrm.rm     = rm;
      w.ri.imm16        = low;
      return w;
   endfunction

   // Expected effect of one instruction word on the model registers
   function automatic void model_execute(input logic [31:0] word);
      pipe_pkg::instr_word_u w;
      logic [31:0] a;
      logic [31:0] b;
      w = word;
      a = model_regs[w.rr.modrm.rm];
      if (w.rr.modrm.mod == pipe_pkg::mod_reg) begin
         b = model_regs[w.rr.modrm.reg_f];
      end else begin
         b = {16'h0000, w.ri.imm16};
      end
      case (w.rr.opcode)
         pipe_pkg::op_add: model_regs[w.rr.modrm.rm] = a + b;
         pipe_pkg::op_or:  model_regs[w.rr.modrm.rm] = a | b;
         pipe_pkg::op_and: model_regs[w.rr.modrm.rm] = a & b;
         pipe_pkg::op_sub: model_regs[w.rr.modrm.rm] = a - b;
         pipe_pkg::op_xor: model_regs[w.rr.modrm.rm] = a ^ b;
         pipe_pkg::op_mov: model_regs[w.rr.modrm.rm] = b;
         default:          ;
      endcase
      // Unknown opcodes retire too
      model_retired = model_retired + 1;
   endfunction

   // Bus tasks start and end just after a falling edge
   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             input int bready_delay, output logic [1:0] resp);
      wr_req.awvalid = 1'b1;
      wr_req.awaddr  = addr;
      wr_req.wvalid  = 1'b1;
      wr_req.wdata   = data;
      while (!(wr_rsp.awready && wr_rsp.wready)) begin
         @(negedge clk);
      end
      // Address and data taken at the rising edge in between
      @(negedge clk);
      wr_req.awvalid = 1'b0;
      wr_req.wvalid  = 1'b0;
      while (!wr_rsp.bvalid) begin
         @(negedge clk);
      end
      repeat (bready_delay) @(negedge clk);
      resp = wr_rsp.bresp;
      wr_req.bready = 1'b1;
      @(negedge clk);
      wr_req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      rd_req.arvalid = 1'b1;
      rd_req.araddr  = addr;
      while (!rd_rsp.arready) begin
         @(negedge clk);
      end
      @(negedge clk);
      rd_req.arvalid = 1'b0;
      while (!rd_rsp.rvalid) begin
         @(negedge clk);
      end
      data = rd_rsp.rdata;
      resp = rd_rsp.rresp;
      rd_req.rready = 1'b1;
      @(negedge clk);
      rd_req.rready = 1'b0;
   endtask

   task automatic send_instr(input logic [31:0] word, input int bready_delay);
      logic [1:0] resp;
      axil_write(pipe_pkg::instr_addr, word, bready_delay, resp);
      assert (resp == pipe_pkg::resp_okay)
      else report_mismatch($sformatf("instruction %08h got bresp %0d", word, resp));
      model_execute(word);
   endtask

   task automatic check_state(input string name);
      check_name = name;
      -> check_now;
      @(check_done);
   endtask

   // Compare process owns the read channel
   initial begin : compare
      logic [31:0] data;
      logic [1:0]  resp;
      rd_req = '0;
      forever begin
         @(check_now);
         // Poll the retired count until every sent op has retired
         do begin
            axil_read(pipe_pkg::retired_addr, data, resp);
            assert (resp == pipe_pkg::resp_okay)
            else report_mismatch($sformatf("%s: count read rresp %0d", check_name, resp));
            assert (data <= model_retired)
            else report_mismatch($sformatf("%s: retired count %0d, model %0d",
                                           check_name, data, model_retired));
         end while (data != model_retired);
         for (int i = 0; i < pipe_pkg::num_gprs; i++) begin
            axil_read(pipe_pkg::addr_w'(4 * i), data, resp);
            assert (resp == pipe_pkg::resp_okay && data == model_regs[i])
            else report_mismatch($sformatf("%s: r%0d read %08h resp %0d, model %08h",
                                           check_name, i, data, resp, model_regs[i]));
         end
         // Unmapped addresses
         for (int p = 0; p < 3; p++) begin
            axil_read(probe_addrs[p], data, resp);
            assert (resp == pipe_pkg::resp_slverr && data == 32'h0)
            else report_mismatch($sformatf("%s: read of %02h gave %08h resp %0d",
                                           check_name, probe_addrs[p], data, resp));
         end
         -> check_done;
      end
   end

   initial begin : stimulus
      logic [1:0]  resp;
      logic [31:0] word;
      logic [2:0]  dest;
      int unsigned pick;
      int          delay;
      wr_req        = '0;
      rst_n         = 1'b0;
      model_retired = '0;
      for (int i = 0; i < pipe_pkg::num_gprs; i++) begin
         model_regs[i] = '0;
      end
      repeat (5) @(negedge clk);
      rst_n = 1'b1;

      // Distinct start values with r7 wrapped below zero
      for (int i = 0; i < pipe_pkg::num_gprs; i++) begin
         send_instr(encode(pipe_pkg::op_mov, 2'b00, 3'd0, 3'(i), 16'(16'h1111 * (i + 1))), 0);
      end
      send_instr(encode(pipe_pkg::op_sub, 2'b00, 3'd0, 3'd7, 16'hffff), 0);
      check_state("register load");

      // Each opcode in both forms with reserved bits set in register form
      for (int k = 0; k < 6; k++) begin
         word = encode(op_by_index(k), pipe_pkg::mod_reg, 3'(k + 3), 3'(k), 16'hbeef);
         send_instr(word, 0);
         check_state($sformatf("opcode %02h register form", op_by_index(k)));
         word = encode(op_by_index(k), 2'b10, 3'(k), 3'(k + 1), 16'(16'h8421 + k * 273));
         send_instr(word, 0);
         check_state($sformatf("opcode %02h immediate form", op_by_index(k)));
      end

      // Back-to-back chain where every op reads the previous destination
      // Writes arrive faster than the stalled issue so the queue fills
      dest = 3'd0;
      for (int k = 0; k < chain_len; k++) begin
         if (k % 2 == 0) begin
            word = encode(op_by_index(k % 6), pipe_pkg::mod_reg, dest, dest + 3'd1, 16'h5a5a);
            dest = dest + 3'd1;
         end else begin
            word = encode(op_by_index(k % 6), 2'b01, 3'd0, dest, 16'(16'h0f0f + k));
         end
         send_instr(word, 0);
      end
      check_state("dependent chain");

      // Unknown opcodes retire without a register write
      send_instr(encode(8'hff, pipe_pkg::mod_reg, 3'd1, 3'd2, 16'h0000), 0);
      send_instr(encode(8'h00, 2'b00, 3'd0, 3'd5, 16'h1234), 0);
      check_state("unknown opcode");

      // Writes outside the instruction address are refused
      axil_write(8'h04, encode(pipe_pkg::op_mov, 2'b00, 3'd0, 3'd1, 16'hdead), 0, resp);
      assert (resp == pipe_pkg::resp_slverr)
      else report_mismatch($sformatf("write to 04 got bresp %0d", resp));
      axil_write(pipe_pkg::retired_addr, 32'h01c1_0000, 1, resp);
      assert (resp == pipe_pkg::resp_slverr)
      else report_mismatch($sformatf("write to 20 got bresp %0d", resp));
      axil_write(8'h01, encode(pipe_pkg::op_add, pipe_pkg::mod_reg, 3'd2, 3'd3, 16'h0), 2, resp);
      assert (resp == pipe_pkg::resp_slverr)
      else report_mismatch($sformatf("write to 01 got bresp %0d", resp));
      check_state("refused writes");

      // Random instructions with random response delays
      for (int n = 0; n < num_random; n++) begin
         word  = $random(seed);
         pick  = $random(seed);
         delay = $random(seed) & 3;
         word[31:24] = op_by_index(int'(pick % 7));
         send_instr(word, delay);
      end
      check_state("random instructions");

      $display("sim passed");
      $finish;
   end

   initial begin : watchdog
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout after %0d cycles, a bus handshake or the pipeline never completed",
               watchdog_cycles);
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

endmodule
